//--- Makefile
VERILATOR  = verilator
SIM_FLAGS  = --binary --timing
LINT_FLAGS = --lint-only --timing
TB_TOP     = tag_subsystem_tb
RTL_TOP    = tag_subsystem
FILELIST   = filelist.f
OBJ_DIR    = obj_dir
PASS_MSG   = All tests passed

.PHONY: lint sim clean

lint:
	$(VERILATOR) $(LINT_FLAGS) -f $(FILELIST) --top-module $(RTL_TOP)

sim:
	$(VERILATOR) $(SIM_FLAGS) -f $(FILELIST) --top-module $(TB_TOP) -Mdir $(OBJ_DIR)
	@out="$$(./$(OBJ_DIR)/V$(TB_TOP))"; echo "$$out"; echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

//--- filelist.f
logic/tag_pkg.sv
logic/tag_launch_sync.sv
logic/tag_client.sv
logic/tag_master.sv
logic/tag_subsystem.sv
tests/tag_subsystem_tb.sv

//--- logic/tag_client.sv
`timescale 1ns/1ns

module tag_client
   #(
      parameter int width_p = 8
   )
   (
      input  logic                bsg_tag_i,
      input  logic                reset_i,
      input  tag_pkg::tag_lines_s tag_lines_i,
      input  logic                recv_clk_i,
      output logic                recv_new_o,
      output logic [width_p-1:0]  recv_data_o
   );

   logic               op_r;
   logic               op_r_r;
   logic               param_r;
   tag_pkg::tag_op_e   dec_op;
   logic               send_now;
   logic [width_p-1:0] tag_data_r;
   logic [width_p-1:0] tag_data_shift;
   logic               tag_toggle_r;
   logic               recv_toggle_n;
   logic               recv_toggle_r;
   logic               recv_new;
   logic               recv_new_r;
   logic               recv_new_r_r;
   logic [width_p-1:0] recv_data_r;

   always_ff @(posedge bsg_tag_i)
   begin
      if (reset_i)
      begin
         op_r    <= 1'b0;
         op_r_r  <= 1'b0;
         param_r <= 1'b0;
      end
      else
      begin
         op_r    <= tag_lines_i.op;
         param_r <= tag_lines_i.param;
         op_r_r  <= op_r;
      end
   end

   assign dec_op = op_r    ? tag_pkg::tag_shift :
                   param_r ? tag_pkg::tag_reset :
                             tag_pkg::tag_noop;

   // shift just ended, the word is complete in tag_data_r
   assign send_now = op_r_r & (dec_op == tag_pkg::tag_noop);

   // first payload bit walks down to bit 0
   if (width_p == 1)
   begin : g_single
      assign tag_data_shift = param_r;
   end
   else
   begin : g_multi
      assign tag_data_shift = {param_r, tag_data_r[width_p-1:1]};
   end

   always_ff @(posedge bsg_tag_i)
   begin
      if (dec_op == tag_pkg::tag_shift)
      begin
         tag_data_r <= tag_data_shift;
      end
   end

   // toggle flips once per sent word and crosses to recv_clk_i
   tag_launch_sync u_launch_sync
      (
         .bsg_tag_i      (bsg_tag_i),
         .launch_reset_i (reset_i | (dec_op == tag_pkg::tag_reset)),
         .launch_data_i  (tag_toggle_r ^ send_now),
         .launch_data_o  (tag_toggle_r),
         .recv_clk_i     (recv_clk_i),
         .sync_data_o    (recv_toggle_n)
      );

   // any toggle edge means a new word, when enabled
   assign recv_new = (recv_toggle_r ^ recv_toggle_n) & tag_lines_i.en;

   always_ff @(posedge recv_clk_i)
   begin
      recv_toggle_r <= recv_toggle_n;
      recv_new_r    <= recv_new;
      recv_new_r_r  <= recv_new_r;
   end

   // tag_data_r is quiet by now, safe to sample in this domain
   always_ff @(posedge recv_clk_i)
   begin
      if (recv_new_r)
      begin
         recv_data_r <= tag_data_r;
      end
   end

   // strobe lands a cycle after the data register loads
   assign recv_new_o  = recv_new_r_r & tag_lines_i.en;
   assign recv_data_o = recv_data_r;

endmodule

//--- logic/tag_launch_sync.sv
`timescale 1ns/1ns

module tag_launch_sync
   (
      input  logic bsg_tag_i,
      input  logic launch_reset_i,
      input  logic launch_data_i,
      output logic launch_data_o,
      input  logic recv_clk_i,
      output logic sync_data_o
   );

   logic launch_r;
   logic sync1_r;
   logic sync2_r;

   // launch flop, the only one here with a reset
   always_ff @(posedge bsg_tag_i)
   begin
      if (launch_reset_i)
      begin
         launch_r <= 1'b0;
      end
      else
      begin
         launch_r <= launch_data_i;
      end
   end

   // two flops in the receive domain
   always_ff @(posedge recv_clk_i)
   begin
      sync1_r <= launch_r;
      sync2_r <= sync1_r;
   end

   assign launch_data_o = launch_r;
   assign sync_data_o   = sync2_r;

endmodule

//--- logic/tag_master.sv
`timescale 1ns/1ns

module tag_master
   (
      input  logic               bsg_tag_i,
      input  logic               reset_i,
      input  logic               tag_data_i,
      input  logic               tag_en_i,
      output tag_pkg::tag_lines_s tag_lines_o [tag_pkg::num_clients_lp]
   );

   tag_pkg::master_state_e                   state_r;
   logic [tag_pkg::node_id_width_lp-1:0]     node_r;
   logic                                     kind_r;
   logic [tag_pkg::len_width_lp-1:0]         len_r;
   logic [tag_pkg::len_width_lp-1:0]         cnt_r;
   logic [tag_pkg::len_width_lp-1:0]         len_n;
   tag_pkg::tag_op_e                         payload_op;
   logic [tag_pkg::num_clients_lp-1:0]       op_r;
   logic [tag_pkg::num_clients_lp-1:0]       param_r;

   // length arrives lsb first, so new bits enter at the top
   assign len_n = {tag_data_i, len_r[tag_pkg::len_width_lp-1:1]};

   // kind bit picks between loading data and resetting the client
   assign payload_op = kind_r ? tag_pkg::tag_shift : tag_pkg::tag_reset;

   always_ff @(posedge bsg_tag_i)
   begin
      if (reset_i)
      begin
         state_r <= tag_pkg::st_idle;
         node_r  <= '0;
         kind_r  <= 1'b0;
         len_r   <= '0;
         cnt_r   <= '0;
      end
      else
      begin
         case (state_r)
            tag_pkg::st_idle:
            begin
               // line idles low, a one is the start bit
               if (tag_data_i)
               begin
                  state_r <= tag_pkg::st_node;
               end
            end
            tag_pkg::st_node:
            begin
               node_r  <= tag_data_i;
               state_r <= tag_pkg::st_kind;
            end
            tag_pkg::st_kind:
            begin
               kind_r  <= tag_data_i;
               cnt_r   <= '0;
               state_r <= tag_pkg::st_len;
            end
            tag_pkg::st_len:
            begin
               len_r <= len_n;
               if (cnt_r == tag_pkg::len_width_lp'(tag_pkg::len_width_lp - 1))
               begin
                  // counter is reused to count payload bits down
                  cnt_r <= len_n;
                  if (len_n == '0)
                  begin
                     state_r <= tag_pkg::st_idle;
                  end
                  else
                  begin
                     state_r <= tag_pkg::st_payload;
                  end
               end
               else
               begin
                  cnt_r <= cnt_r + 1'b1;
               end
            end
            tag_pkg::st_payload:
            begin
               cnt_r <= cnt_r - 1'b1;
               if (cnt_r == tag_pkg::len_width_lp'(1))
               begin
                  state_r <= tag_pkg::st_idle;
               end
            end
            default:
            begin
               state_r <= tag_pkg::st_idle;
            end
         endcase
      end
   end

   // registered lines, one cycle behind the sampled payload bit
   always_ff @(posedge bsg_tag_i)
   begin
      if (reset_i)
      begin
         op_r    <= '0;
         param_r <= '0;
      end
      else
      begin
         for (int i = 0; i < tag_pkg::num_clients_lp; i++)
         begin
            if ((state_r == tag_pkg::st_payload)
                && (node_r == tag_pkg::node_id_width_lp'(i)))
            begin
               op_r[i]    <= (payload_op == tag_pkg::tag_shift);
               param_r[i] <= (payload_op == tag_pkg::tag_shift) ? tag_data_i : 1'b1;
            end
            else
            begin
               // no-op everywhere else
               op_r[i]    <= 1'b0;
               param_r[i] <= 1'b0;
            end
         end
      end
   end

   // en is a plain level copied to every client
   always_comb
   begin
      for (int i = 0; i < tag_pkg::num_clients_lp; i++)
      begin
         tag_lines_o[i].op    = op_r[i];
         tag_lines_o[i].param = param_r[i];
         tag_lines_o[i].en    = tag_en_i;
      end
   end

endmodule

//--- logic/tag_pkg.sv
package tag_pkg;

   // network shape
   localparam int num_clients_lp   = 2;
   localparam int node_id_width_lp = 1;
   localparam int len_width_lp     = 4;

   // client word widths
   localparam int client0_width_lp = 8;
   localparam int client1_width_lp = 4;

   // three wires from the master to one client
   // op=1 means shift with param as the data bit
   // op=0, param=1 is the in-band reset
   // op=0, param=0 is a no-op
   typedef struct packed
   {
      logic op;
      logic param;
      logic en;
   } tag_lines_s;

   // meaning of an op/param pair
   typedef enum logic [1:0]
   {
      tag_noop  = 2'd0,
      tag_reset = 2'd1,
      tag_shift = 2'd2
   } tag_op_e;

   // packet decoder states
   typedef enum logic [2:0]
   {
      st_idle    = 3'd0,
      st_node    = 3'd1,
      st_kind    = 3'd2,
      st_len     = 3'd3,
      st_payload = 3'd4
   } master_state_e;

endpackage

//--- logic/tag_subsystem.sv
`timescale 1ns/1ns

module tag_subsystem
   (
      input  logic                                  bsg_tag_i,
      input  logic                                  reset_i,
      input  logic                                  tag_data_i,
      input  logic                                  tag_en_i,
      input  logic                                  recv_clk_i,
      output logic                                  recv0_new_o,
      output logic [tag_pkg::client0_width_lp-1:0]  recv0_data_o,
      output logic                                  recv1_new_o,
      output logic [tag_pkg::client1_width_lp-1:0]  recv1_data_o
   );

   tag_pkg::tag_lines_s tag_lines [tag_pkg::num_clients_lp];

   tag_master u_master
      (
         .bsg_tag_i   (bsg_tag_i),
         .reset_i     (reset_i),
         .tag_data_i  (tag_data_i),
         .tag_en_i    (tag_en_i),
         .tag_lines_o (tag_lines)
      );

   // node 0, wide word
   tag_client #(.width_p(tag_pkg::client0_width_lp)) u_client0
      (
         .bsg_tag_i   (bsg_tag_i),
         .reset_i     (reset_i),
         .tag_lines_i (tag_lines[0]),
         .recv_clk_i  (recv_clk_i),
         .recv_new_o  (recv0_new_o),
         .recv_data_o (recv0_data_o)
      );

   // node 1, narrow word
   tag_client #(.width_p(tag_pkg::client1_width_lp)) u_client1
      (
         .bsg_tag_i   (bsg_tag_i),
         .reset_i     (reset_i),
         .tag_lines_i (tag_lines[1]),
         .recv_clk_i  (recv_clk_i),
         .recv_new_o  (recv1_new_o),
         .recv_data_o (recv1_data_o)
      );

endmodule

//--- tests/tag_subsystem_tb.sv
`timescale 1ns/1ns

module tag_subsystem_tb;

   // one packet and its expected outcome
   typedef struct packed
   {
      logic       node;
      logic       kind;
      logic [7:0] payload;
      logic       en;
      logic       strobe;
   } row_s;

   localparam int num_rows_lp = 13;

   logic                                 bsg_tag_i;
   logic                                 reset_i;
   logic                                 tag_data_i;
   logic                                 tag_en_i;
   logic                                 recv_clk_i;
   logic                                 recv0_new_o;
   logic [tag_pkg::client0_width_lp-1:0] recv0_data_o;
   logic                                 recv1_new_o;
   logic [tag_pkg::client1_width_lp-1:0] recv1_data_o;

   row_s        table_r [num_rows_lp];
   int          count0;
   int          count1;
   int          error_count;
   int          checks_done;
   int          seed;
   logic [31:0] rnd;
   logic [7:0]  exp0;
   logic [3:0]  exp1;
   logic        valid0;
   logic        valid1;

   tag_subsystem uut
      (
         .bsg_tag_i    (bsg_tag_i),
         .reset_i      (reset_i),
         .tag_data_i   (tag_data_i),
         .tag_en_i     (tag_en_i),
         .recv_clk_i   (recv_clk_i),
         .recv0_new_o  (recv0_new_o),
         .recv0_data_o (recv0_data_o),
         .recv1_new_o  (recv1_new_o),
         .recv1_data_o (recv1_data_o)
      );

   initial
   begin
      bsg_tag_i = 1'b0;
      forever #5 bsg_tag_i = ~bsg_tag_i;
   end

   // receive clock is unrelated to the tag clock, offset so its edges miss input changes
   initial
   begin
      recv_clk_i = 1'b0;
      #2;
      forever #7 recv_clk_i = ~recv_clk_i;
   end

   // strobes are one receive cycle wide, the falling edge sees each once
   always @(negedge recv_clk_i)
   begin
      if (recv0_new_o === 1'b1)
      begin
         count0 = count0 + 1;
      end
      if (recv1_new_o === 1'b1)
      begin
         count1 = count1 + 1;
      end
   end

   function automatic row_s make_row(input logic node, input logic kind,
                                     input logic [7:0] payload, input logic en,
                                     input logic strobe);
      make_row = {node, kind, payload, en, strobe};
   endfunction

   task automatic drive_bit(input logic b);
      @(posedge bsg_tag_i);
      #1;
      tag_data_i = b;
   endtask

   task automatic idle_cycles(input int n);
      for (int i = 0; i < n; i++)
      begin
         drive_bit(1'b0);
      end
   endtask

   // start bit, node, kind, length lsb first, payload lsb first
   task automatic send_packet(input row_s r);
      int                               nbits;
      logic [tag_pkg::len_width_lp-1:0] len_bits;
      nbits = r.node ? tag_pkg::client1_width_lp : tag_pkg::client0_width_lp;
      len_bits = tag_pkg::len_width_lp'(nbits);
      drive_bit(1'b1);
      drive_bit(r.node);
      drive_bit(r.kind);
      for (int i = 0; i < tag_pkg::len_width_lp; i++)
      begin
         drive_bit(len_bits[i]);
      end
      for (int i = 0; i < nbits; i++)
      begin
         drive_bit(r.payload[i]);
      end
      idle_cycles(3);
   endtask

   task automatic compare_data(input string name, input logic [7:0] got,
                               input logic [7:0] expected);
      checks_done = checks_done + 1;
      if (got !== expected)
      begin
         $display("ERR %s got %h expected %h", name, got, expected);
         error_count = error_count + 1;
      end
   endtask

   task automatic verify_pulses(input string name, input int got, input int expected);
      checks_done = checks_done + 1;
      if (got != expected)
      begin
         $display("%s pulsed %0d times instead of %0d", name, got, expected);
         error_count = error_count + 1;
      end
   endtask

   task automatic run_row(input row_s r);
      int   before0;
      int   before1;
      int   waited;
      logic seen;
      drive_bit(1'b0);
      tag_en_i = r.en;
      before0 = count0;
      before1 = count1;
      send_packet(r);
      waited = 0;
      seen = 1'b0;
      // rows without a strobe run the whole window
      while (!seen && (waited < 200))
      begin
         drive_bit(1'b0);
         waited = waited + 1;
         seen = r.node ? (count1 != before1) : (count0 != before0);
      end
      if (r.strobe && !seen)
      begin
         $display("no strobe from client %0d within 200 cycles", r.node);
         error_count = error_count + 1;
      end
      idle_cycles(20);
      if (r.kind && r.en)
      begin
         if (r.node)
         begin
            exp1 = r.payload[3:0];
            valid1 = 1'b1;
         end
         else
         begin
            exp0 = r.payload;
            valid0 = 1'b1;
         end
      end
      verify_pulses("recv0_new_o", count0 - before0, (!r.node && r.strobe) ? 1 : 0);
      verify_pulses("recv1_new_o", count1 - before1, (r.node && r.strobe) ? 1 : 0);
      if (valid0)
      begin
         compare_data("recv0_data_o", recv0_data_o, exp0);
      end
      if (valid1)
      begin
         compare_data("recv1_data_o", {4'h0, recv1_data_o}, {4'h0, exp1});
      end
   endtask

   initial
   begin
      reset_i = 1'b1;
      tag_data_i = 1'b0;
      tag_en_i = 1'b0;
      count0 = 0;
      count1 = 0;
      error_count = 0;
      checks_done = 0;
      valid0 = 1'b0;
      valid1 = 1'b0;
      exp0 = 8'h00;
      exp1 = 4'h0;
      seed = 52760;
      table_r[0] = make_row(1'b0, 1'b1, 8'ha5, 1'b1, 1'b1);
      table_r[1] = make_row(1'b1, 1'b1, 8'h06, 1'b1, 1'b1);
      // disabled word still flips the toggle but must not strobe
      table_r[2] = make_row(1'b0, 1'b1, 8'h3c, 1'b0, 1'b0);
      table_r[3] = make_row(1'b0, 1'b1, 8'h5a, 1'b1, 1'b1);
      // fourth word to node 0 leaves its toggle at zero before the reset
      table_r[4] = make_row(1'b0, 1'b1, 8'hc3, 1'b1, 1'b1);
      table_r[5] = make_row(1'b0, 1'b0, 8'h00, 1'b1, 1'b0);
      table_r[6] = make_row(1'b0, 1'b1, 8'h96, 1'b1, 1'b1);
      for (int i = 7; i < num_rows_lp; i++)
      begin
         rnd = $random(seed);
         if ((i % 2) == 1)
         begin
            table_r[i] = make_row(1'b1, 1'b1, {4'h0, rnd[3:0]}, 1'b1, 1'b1);
         end
         else
         begin
            table_r[i] = make_row(1'b0, 1'b1, rnd[7:0], 1'b1, 1'b1);
         end
      end
      repeat (16) @(posedge bsg_tag_i);
      #1;
      reset_i = 1'b0;
      tag_en_i = 1'b1;
      idle_cycles(40);
      verify_pulses("recv0_new_o", count0, 0);
      verify_pulses("recv1_new_o", count1, 0);
      for (int i = 0; i < num_rows_lp; i++)
      begin
         run_row(table_r[i]);
      end
      $display("%0d checks, %0d errors", checks_done, error_count);
      if (error_count == 0)
      begin
         $display("All tests passed");
      end
      else
      begin
         $display("Some tests failed");
      end
      $finish;
   end

endmodule
